/* sd_sector_reader.f */
+incdir+source
source/sd_pkg.sv
source/sector_buffer.sv
source/sd_cmd_ctrl.sv
source/sd_reader.sv
source/sd_sector_reader.sv
test/sd_card_model.sv
test/sd_reader_properties.sv
test/tb_sd_sector_reader.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_sd_sector_reader \
    --Mdir obj_dir \
    -f sd_sector_reader.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_sd_sector_reader > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* test/tb_sd_sector_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sd_defines.svh"

module tb_sd_sector_reader;

    import sd_pkg::*;

    // limits in clk cycles
    localparam int INIT_TIMEOUT = 200000;
    localparam int READ_TIMEOUT = 60000;

    logic          clk;
    logic          rst_n;
    logic          rstart;
    logic [31:0]   rsector_no;
    logic [8:0]    rd_addr;
    logic [7:0]    rd_data;
    logic          rbusy;
    logic          rdone;
    logic          sdclk;
    wire           sdcmd;
    wire  [3:0]    sddat;
    card_type_e    card_type;
    reader_state_e card_stat;
    integer        seed;

    pullup (sdcmd);

    sd_sector_reader i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .sdclk      (sdclk),
        .sdcmd      (sdcmd),
        .sddat      (sddat),
        .card_type  (card_type),
        .card_stat  (card_stat),
        .rstart     (rstart),
        .rsector_no (rsector_no),
        .rbusy      (rbusy),
        .rdone      (rdone),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    sd_card_model i_card (
        .sdclk (sdclk),
        .sdcmd (sdcmd),
        .sddat (sddat)
    );

    always #2 clk = ~clk;

    // byte i of block b
    function automatic logic [7:0] expected_byte(input logic [31:0] block, input int i);
        return (block[7:0] + i[7:0]) ^ 8'h5a;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0d ns: gave up waiting for %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic apply_reset(input logic ccs_mode);
        i_card.ccs = ccs_mode;
        @(negedge clk);
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        check_value("rdone", 32'(rdone), 32'd0);
        check_value("rbusy", 32'(rbusy), 32'd1);
        check_value("sdclk", 32'(sdclk), 32'd0);
        check_value("sdcmd", 32'(sdcmd), 32'd1);
        rst_n = 1'b1;
    endtask

    task automatic wait_init_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(card_stat == ST_IDLE && !rbusy)) begin
            if (cycles == INIT_TIMEOUT) begin
                report_timeout("card initialization");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic start_read(input logic [31:0] sector);
        @(negedge clk);
        rstart     = 1'b1;
        rsector_no = sector;
        @(negedge clk);
        rstart = 1'b0;
        check_value("rbusy", 32'(rbusy), 32'd1);
    endtask

    task automatic wait_rdone();
        int cycles;
        cycles = 0;
        while (rdone !== 1'b1) begin
            if (cycles == READ_TIMEOUT) begin
                report_timeout("rdone");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // the read port is registered so the address leads the data by one cycle
    task automatic check_buffer(input logic [31:0] block);
        @(negedge clk);
        rd_addr = 9'd0;
        for (int i = 0; i < `SD_SECTOR_BYTES; i++) begin
            @(negedge clk);
            check_value($sformatf("rd_data[%0d]", i), 32'(rd_data), 32'(expected_byte(block, i)));
            rd_addr = 9'(i + 1);
        end
    endtask

    task automatic read_and_check(input logic [31:0] sector);
        start_read(sector);
        wait_rdone();
        check_buffer(sector);
    endtask

    task automatic init_sdhc_card();
        apply_reset(1'b1);
        wait_init_done();
        check_value("card_type", 32'(card_type), 32'(CARD_SDHCV2));
    endtask

    task automatic read_random_sector();
        logic [31:0] sector;
        sector = $random(seed);
        read_and_check(sector);
    endtask

    task automatic ignore_busy_strobes();
        start_read(32'd7);
        for (int n = 0; n < 3; n++) begin
            repeat (40) @(negedge clk);
            check_value("rbusy", 32'(rbusy), 32'd1);
            check_value("rdone", 32'(rdone), 32'd0);
            rstart     = 1'b1;
            rsector_no = 32'd9 + 32'(n);
            @(negedge clk);
            rstart = 1'b0;
        end
        wait_rdone();
        // a second rdone would mean a strobe was taken
        for (int n = 0; n < 300; n++) begin
            @(negedge clk);
            check_value("rdone", 32'(rdone), 32'd0);
            check_value("card_stat", 32'(card_stat), 32'(ST_IDLE));
        end
        check_buffer(32'd7);
    endtask

    task automatic retry_dropped_block();
        i_card.drops_wanted = 1;
        read_and_check(32'd11);
        check_value("drops_done", 32'(i_card.drops_done), 32'd1);
    endtask

    task automatic read_standard_card();
        apply_reset(1'b0);
        wait_init_done();
        check_value("card_type", 32'(card_type), 32'(CARD_SDV2));
        read_and_check(32'd5);
    endtask

    initial begin
        clk                 = 1'b0;
        rst_n               = 1'b0;
        rstart              = 1'b0;
        rsector_no          = '0;
        rd_addr             = '0;
        seed                = 48628;
        i_card.drops_wanted = 0;
        init_sdhc_card();
        read_and_check(32'd3);
        read_random_sector();
        ignore_busy_strobes();
        retry_dropped_block();
        read_standard_card();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/sd_reader_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_reader_properties (
    input wire clk,
    input wire rst_n,
    input wire rdone,
    input wire rbusy,
    input wire cmd_start,
    input wire cmd_busy
);

    rdone_single: assert property (@(posedge clk) disable iff (!rst_n) rdone |=> !rdone)
        else $error("rdone held high for more than one cycle");

    // the reader is free again right after the done pulse
    busy_ends_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        rdone |=> !rbusy)
        else $error("rbusy still high the cycle after rdone");

    // one command in flight at a time
    start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_start |-> !cmd_busy)
        else $error("cmd_start issued while the command engine is busy");

endmodule

bind sd_reader sd_reader_properties i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdone     (rdone),
    .rbusy     (rbusy),
    .cmd_start (cmd_start),
    .cmd_busy  (cmd_busy)
);

`default_nettype wire

/* test/sd_card_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
    input  wire        sdclk,
    inout  wire        sdcmd,
    output logic [3:0] sddat
);

    // written by the testbench
    logic        ccs;
    int          drops_wanted;

    int          drops_done;
    int          acmd41_count;
    logic        cmd_oe;
    logic        cmd_out;
    logic [15:0] rca;
    logic [5:0]  cmd_index;
    logic [31:0] cmd_arg;

    assign sdcmd = cmd_oe ? cmd_out : 1'bz;

    // 48-bit R1/R3/R6 frame, CRC left at zero since the host ignores it
    function automatic logic [135:0] short_resp(input logic [5:0] index, input logic [31:0] arg);
        return {88'h0, 2'b00, index, arg, 7'h00, 1'b1};
    endfunction

    // host drives on falling sdclk, card samples on rising
    task automatic receive_command(output logic [5:0] index, output logic [31:0] arg);
        logic [47:0] frame;
        @(posedge sdclk);
        while (sdcmd !== 1'b0) begin
            @(posedge sdclk);
        end
        frame = '0;
        for (int i = 0; i < 47; i++) begin
            @(posedge sdclk);
            frame = {frame[46:0], sdcmd};
        end
        index = frame[45:40];
        arg   = frame[39:8];
    endtask

    // first falling edge is where the host releases the line
    task automatic send_response(input logic [135:0] bits, input int count);
        @(negedge sdclk);
        for (int i = count - 1; i >= 0; i--) begin
            @(negedge sdclk);
            cmd_oe  = 1'b1;
            cmd_out = bits[i];
        end
        @(negedge sdclk);
        cmd_oe  = 1'b0;
        cmd_out = 1'b1;
    endtask

    // start bit, 4096 data bits MSB first, CRC16 as zeros, end bit
    task automatic send_block(input logic [31:0] block);
        logic [7:0] value;
        repeat (2) @(negedge sdclk);
        sddat[0] = 1'b0;
        for (int i = 0; i < 512; i++) begin
            value = (block[7:0] + i[7:0]) ^ 8'h5a;
            for (int b = 7; b >= 0; b--) begin
                @(negedge sdclk);
                sddat[0] = value[b];
            end
        end
        repeat (16) begin
            @(negedge sdclk);
            sddat[0] = 1'b0;
        end
        @(negedge sdclk);
        sddat[0] = 1'b1;
    endtask

    task automatic serve_read(input logic [31:0] arg);
        send_response(short_resp(6'd17, 32'h0000_0900), 48);
        if (drops_done < drops_wanted) begin
            drops_done++;
        end else if (ccs) begin
            send_block(arg);
        end else if (arg[8:0] == 9'd0) begin
            send_block(arg >> 9);
        end
    endtask

    initial begin
        cmd_oe       = 1'b0;
        cmd_out      = 1'b1;
        sddat        = 4'hf;
        rca          = 16'h0;
        acmd41_count = 0;
        drops_done   = 0;
        forever begin
            receive_command(cmd_index, cmd_arg);
            case (cmd_index)
                // CMD0 has no response
                6'd0: acmd41_count = 0;
                6'd8: send_response(short_resp(6'd8, cmd_arg), 48);
                6'd55: send_response(short_resp(6'd55, 32'h0000_0120), 48);
                // still busy on the first ACMD41
                6'd41: begin
                    acmd41_count++;
                    send_response(short_resp(6'h3f, {acmd41_count > 1, ccs, 30'h00ff8000}),
                                  48);
                end
                6'd2: send_response({2'b00, 6'h3f, 127'h2a, 1'b1}, 136);
                6'd3: begin
                    rca = 16'hb36e;
                    send_response(short_resp(6'd3, {rca, 16'h0500}), 48);
                end
                6'd7: begin
                    if (cmd_arg[31:16] == rca) begin
                        send_response(short_resp(6'd7, 32'h0000_0700), 48);
                    end
                end
                6'd16: send_response(short_resp(6'd16, 32'h0000_0900), 48);
                6'd17: serve_read(cmd_arg);
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/sd_sector_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_sector_reader (
    input  wire                   clk,
    input  wire                   rst_n,
    output logic                  sdclk,
    inout  wire                   sdcmd,
    input  wire [3:0]             sddat,
    output sd_pkg::card_type_e    card_type,
    output sd_pkg::reader_state_e card_stat,
    input  wire                   rstart,
    input  wire [31:0]            rsector_no,
    output logic                  rbusy,
    output logic                  rdone,
    input  wire [8:0]             rd_addr,
    output logic [7:0]            rd_data
);

    import sd_pkg::*;

    logic         cmd_start;
    sd_cmd_t      cmd;
    logic         cmd_busy;
    logic         cmd_done;
    sd_resp_u     resp;
    logic         timeout;
    logic         syntax_err;
    logic         sdcmd_oe;
    logic         sdcmd_out;
    sector_byte_t wr;

    assign sdcmd = sdcmd_oe ? sdcmd_out : 1'bz;

    // 1-bit bus mode, only DAT0 carries data
    sd_reader i_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .sdclk      (sdclk),
        .sddat0     (sddat[0]),
        .rstart     (rstart),
        .rsector_no (rsector_no),
        .rbusy      (rbusy),
        .rdone      (rdone),
        .card_type  (card_type),
        .card_stat  (card_stat),
        .cmd_start  (cmd_start),
        .cmd        (cmd),
        .cmd_busy   (cmd_busy),
        .cmd_done   (cmd_done),
        .resp       (resp),
        .timeout    (timeout),
        .syntax_err (syntax_err),
        .wr         (wr)
    );

    sd_cmd_ctrl i_cmd_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_start  (cmd_start),
        .cmd        (cmd),
        .cmd_busy   (cmd_busy),
        .cmd_done   (cmd_done),
        .resp       (resp),
        .timeout    (timeout),
        .syntax_err (syntax_err),
        .sdclk      (sdclk),
        .sdcmd_oe   (sdcmd_oe),
        .sdcmd_out  (sdcmd_out),
        .sdcmd_in   (sdcmd)
    );

    sector_buffer i_buffer (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* source/sd_reader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sd_defines.svh"

module sd_reader (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      sdclk,
    input  wire                      sddat0,
    input  wire                      rstart,
    input  wire [31:0]               rsector_no,
    output logic                     rbusy,
    output logic                     rdone,
    output sd_pkg::card_type_e       card_type,
    output sd_pkg::reader_state_e    card_stat,
    output logic                     cmd_start,
    output sd_pkg::sd_cmd_t          cmd,
    input  wire                      cmd_busy,
    input  wire                      cmd_done,
    input  wire sd_pkg::sd_resp_u    resp,
    input  wire                      timeout,
    input  wire                      syntax_err,
    output sd_pkg::sector_byte_t     wr
);

    import sd_pkg::*;

    localparam logic [2:0] R_WAIT    = 3'd0;
    localparam logic [2:0] R_DATA    = 3'd1;
    localparam logic [2:0] R_TAIL    = 3'd2;
    localparam logic [2:0] R_DONE    = 3'd3;
    localparam logic [2:0] R_TIMEOUT = 3'd4;

    reader_state_e state;
    logic          v1_maybe;
    logic [15:0]   rca;
    logic [31:0]   rsector_addr;
    logic          resp_ok;
    logic [2:0]    rstate;
    logic [31:0]   ridx;
    logic          sdclk_q;

    assign card_stat = state;
    assign rbusy     = (state != ST_IDLE) | rdone;
    assign resp_ok   = ~timeout & ~syntax_err;

    // command request follows the state; latched by the engine on cmd_start
    always_comb begin
        cmd.index     = 6'd17;
        cmd.arg       = rsector_addr;
        cmd.precycles = 16'd20;
        cmd.clkdiv    = `SD_SLOW_DIV;
        cmd.long_resp = 1'b0;
        case (state)
            ST_CMD0: begin
                cmd.index     = 6'd0;
                cmd.arg       = 32'h0;
                cmd.precycles = `SD_INIT_PRECYCLES;
            end
            ST_CMD8: begin
                cmd.index = 6'd8;
                cmd.arg   = 32'h0000_01aa;
            end
            ST_CMD55: begin
                cmd.index = 6'd55;
                cmd.arg   = 32'h0;
            end
            // HCS set, 3.2-3.3V window
            ST_ACMD41: begin
                cmd.index = 6'd41;
                cmd.arg   = 32'hc010_0000;
            end
            ST_CMD2: begin
                cmd.index     = 6'd2;
                cmd.arg       = 32'h0;
                cmd.long_resp = 1'b1;
            end
            ST_CMD3: begin
                cmd.index = 6'd3;
                cmd.arg   = 32'h0;
            end
            ST_CMD7: begin
                cmd.index = 6'd7;
                cmd.arg   = {rca, 16'h0};
            end
            ST_CMD16: begin
                cmd.index  = 6'd16;
                cmd.arg    = 32'(`SD_SECTOR_BYTES);
                cmd.clkdiv = `SD_FAST_DIV;
            end
            default: begin
                cmd.precycles = 16'd16;
                cmd.clkdiv    = `SD_FAST_DIV;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_CMD0;
            card_type    <= CARD_UNKNOWN;
            v1_maybe     <= 1'b0;
            rca          <= '0;
            rsector_addr <= '0;
            cmd_start    <= 1'b0;
            rdone        <= 1'b0;
        end else begin
            cmd_start <= 1'b0;
            rdone     <= 1'b0;
            if (state == ST_READING2) begin
                if (rstate == R_TIMEOUT) begin
                    cmd_start <= 1'b1;
                    state     <= ST_READING;
                end else if (rstate == R_DONE) begin
                    rdone <= 1'b1;
                    state <= ST_IDLE;
                end
            end else if (cmd_busy) begin
                if (cmd_done) begin
                    case (state)
                        ST_CMD0: state <= ST_CMD8;
                        // no answer to CMD8 points to a v1 card
                        ST_CMD8: if (timeout) begin
                            v1_maybe <= 1'b1;
                            state    <= ST_CMD55;
                        end else if (!syntax_err && resp.rca_resp.status[7:0] == 8'haa) begin
                            state <= ST_CMD55;
                        end
                        ST_CMD55: if (resp_ok) state <= ST_ACMD41;
                        ST_ACMD41: if (resp_ok && resp.ocr.ready) begin
                            card_type <= v1_maybe ? CARD_SDV1 :
                                         (resp.ocr.ccs ? CARD_SDHCV2 : CARD_SDV2);
                            state     <= ST_CMD2;
                        end else begin
                            state <= ST_CMD55;
                        end
                        ST_CMD2: if (resp_ok) state <= ST_CMD3;
                        ST_CMD3: if (resp_ok) begin
                            rca   <= resp.rca_resp.rca;
                            state <= ST_CMD7;
                        end
                        ST_CMD7: if (resp_ok) state <= ST_CMD16;
                        ST_CMD16: if (resp_ok) state <= ST_IDLE;
                        ST_READING: if (resp_ok) begin
                            state <= ST_READING2;
                        end else begin
                            cmd_start <= 1'b1;
                        end
                        default: ;
                    endcase
                end
            end else if (!cmd_start && state != ST_READING) begin
                if (state != ST_IDLE) begin
                    cmd_start <= 1'b1;
                end else if (rstart && !rbusy) begin
                    // SDHC takes block numbers, older cards byte offsets
                    rsector_addr <= (card_type == CARD_SDHCV2) ? rsector_no : rsector_no << 9;
                    cmd_start    <= 1'b1;
                    state        <= ST_READING;
                end
            end
        end
    end

    // DAT0 capture on rising sdclk edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sdclk_q <= 1'b0;
            rstate  <= R_WAIT;
            ridx    <= '0;
            wr      <= '0;
        end else begin
            sdclk_q  <= sdclk;
            wr.wr_en <= 1'b0;
            if ((state != ST_READING && state != ST_READING2) || rstate == R_TIMEOUT) begin
                rstate <= R_WAIT;
                ridx   <= '0;
            end else if (sdclk && !sdclk_q) begin
                case (rstate)
                    R_WAIT: if (!sddat0) begin
                        rstate <= R_DATA;
                        ridx   <= '0;
                    end else if (ridx == `SD_DAT_TIMEOUT) begin
                        rstate <= R_TIMEOUT;
                    end else begin
                        ridx <= ridx + 32'd1;
                    end
                    // MSB first, the data field doubles as the shift register
                    R_DATA: begin
                        wr.data <= {wr.data[6:0], sddat0};
                        if (ridx[2:0] == 3'd7) begin
                            wr.wr_en <= 1'b1;
                            wr.addr  <= ridx[11:3];
                        end
                        if (ridx == `SD_SECTOR_BYTES * 8 - 1) begin
                            rstate <= R_TAIL;
                            ridx   <= '0;
                        end else begin
                            ridx <= ridx + 32'd1;
                        end
                    end
                    // CRC16 and end bit are not checked
                    R_TAIL: if (ridx == 32'd63) begin
                        rstate <= R_DONE;
                    end else begin
                        ridx <= ridx + 32'd1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* source/sd_cmd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sd_defines.svh"

module sd_cmd_ctrl (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 cmd_start,
    input  wire sd_pkg::sd_cmd_t cmd,
    output logic                cmd_busy,
    output logic                cmd_done,
    output sd_pkg::sd_resp_u    resp,
    output logic                timeout,
    output logic                syntax_err,
    output logic                sdclk,
    output logic                sdcmd_oe,
    output logic                sdcmd_out,
    input  wire                 sdcmd_in
);

    localparam logic [2:0] PH_IDLE = 3'd0;
    localparam logic [2:0] PH_PRE  = 3'd1;
    localparam logic [2:0] PH_TX   = 3'd2;
    localparam logic [2:0] PH_WAIT = 3'd3;
    localparam logic [2:0] PH_RX   = 3'd4;
    localparam logic [2:0] PH_DONE = 3'd5;

    logic [2:0]  phase;
    logic [15:0] clkdiv;
    logic [15:0] div_cnt;
    logic [15:0] pre_cnt;
    logic [5:0]  tx_cnt;
    logic [14:0] wait_cnt;
    logic [7:0]  rx_cnt;
    logic        long_resp;
    logic        tbit_err;
    logic [47:0] tx_bits;
    logic [38:0] rx_shift;
    logic [39:0] frame;
    logic        tick;
    logic        fall;
    logic        rise;
    logic        tx_step;
    logic        rx_last;

    // CRC7, polynomial x^7 + x^3 + 1
    function automatic logic [6:0] crc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    // start bit, transmission bit, index, argument
    assign frame = {2'b01, cmd.index, cmd.arg};

    // sdclk free-runs at the last requested rate
    assign tick = (div_cnt >= clkdiv);
    assign fall = tick & sdclk;
    assign rise = tick & ~sdclk;

    // next falling edge drives a command bit once the preamble is over
    assign tx_step = fall && tx_cnt != 6'd48
                     && ((phase == PH_PRE && pre_cnt == '0) || phase == PH_TX);
    assign rx_last = (rx_cnt == (long_resp ? 8'd135 : 8'd47));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= PH_IDLE;
            cmd_busy   <= 1'b0;
            cmd_done   <= 1'b0;
            timeout    <= 1'b0;
            syntax_err <= 1'b0;
            sdclk      <= 1'b0;
            sdcmd_oe   <= 1'b0;
            sdcmd_out  <= 1'b1;
            clkdiv     <= `SD_SLOW_DIV;
            long_resp  <= 1'b0;
            div_cnt    <= '0;
            pre_cnt    <= '0;
            tx_cnt     <= '0;
            wait_cnt   <= '0;
            rx_cnt     <= '0;
            tbit_err   <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            if (tick) begin
                div_cnt <= '0;
                sdclk   <= ~sdclk;
            end else begin
                div_cnt <= div_cnt + 16'd1;
            end

            if (tx_step) begin
                sdcmd_oe  <= 1'b1;
                sdcmd_out <= tx_bits[47];
                tx_cnt    <= tx_cnt + 6'd1;
                phase     <= PH_TX;
            end else begin
                case (phase)
                    PH_IDLE: if (cmd_start) begin
                        cmd_busy   <= 1'b1;
                        timeout    <= 1'b0;
                        syntax_err <= 1'b0;
                        clkdiv     <= cmd.clkdiv;
                        long_resp  <= cmd.long_resp;
                        pre_cnt    <= cmd.precycles;
                        tx_cnt     <= '0;
                        phase      <= PH_PRE;
                    end
                    PH_PRE: if (fall) begin
                        pre_cnt <= pre_cnt - 16'd1;
                    end
                    // end bit is out, release the line
                    PH_TX: if (fall) begin
                        sdcmd_oe <= 1'b0;
                        wait_cnt <= '0;
                        phase    <= PH_WAIT;
                    end
                    PH_WAIT: if (rise) begin
                        if (!sdcmd_in) begin
                            rx_cnt <= 8'd1;
                            phase  <= PH_RX;
                        end else if (wait_cnt == `SD_CMD_TIMEOUT) begin
                            timeout  <= 1'b1;
                            cmd_done <= 1'b1;
                            phase    <= PH_DONE;
                        end else begin
                            wait_cnt <= wait_cnt + 15'd1;
                        end
                    end
                    PH_RX: if (rise) begin
                        if (rx_cnt == 8'd1) begin
                            tbit_err <= sdcmd_in;
                        end
                        if (rx_last) begin
                            syntax_err <= tbit_err | ~sdcmd_in;
                            cmd_done   <= 1'b1;
                            phase      <= PH_DONE;
                        end else begin
                            rx_cnt <= rx_cnt + 8'd1;
                        end
                    end
                    default: begin
                        cmd_busy <= 1'b0;
                        phase    <= PH_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && cmd_start) begin
            tx_bits <= {frame, crc7(frame), 1'b1};
        end else if (tx_step) begin
            tx_bits <= {tx_bits[46:0], 1'b1};
        end
        // on the end bit, the 39 bits before it are argument and CRC
        if (phase == PH_RX && rise) begin
            rx_shift <= {rx_shift[37:0], sdcmd_in};
            if (rx_last && !long_resp) begin
                resp <= rx_shift[38:7];
            end
        end
    end

endmodule

`default_nettype wire

/* source/sector_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sd_defines.svh"

module sector_buffer (
    input  wire                       clk,
    input  wire sd_pkg::sector_byte_t wr,
    input  wire [8:0]                 rd_addr,
    output logic [7:0]                rd_data
);

    logic [7:0] mem [`SD_SECTOR_BYTES];

    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            mem[wr.addr] <= wr.data;
        end
        // registered read, one clk of latency
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* source/sd_pkg.sv */
`default_nettype none

package sd_pkg;

    typedef enum logic [1:0] {
        CARD_UNKNOWN,
        CARD_SDV1,
        CARD_SDV2,
        CARD_SDHCV2
    } card_type_e;

    // init sequence first, then the read states
    typedef enum logic [3:0] {
        ST_CMD0     = 4'd0,
        ST_CMD8     = 4'd1,
        ST_CMD55    = 4'd2,
        ST_ACMD41   = 4'd3,
        ST_CMD2     = 4'd4,
        ST_CMD3     = 4'd5,
        ST_CMD7     = 4'd6,
        ST_CMD16    = 4'd7,
        ST_IDLE     = 4'd8,
        ST_READING  = 4'd9,
        ST_READING2 = 4'd10
    } reader_state_e;

    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic [15:0] precycles;
        logic [15:0] clkdiv;
        logic        long_resp;
    } sd_cmd_t;

    // R3 layout
    typedef struct packed {
        logic        ready;
        logic        ccs;
        logic [29:0] other;
    } ocr_t;

    // R6 layout
    typedef struct packed {
        logic [15:0] rca;
        logic [15:0] status;
    } rca_resp_t;

    typedef union packed {
        ocr_t      ocr;
        rca_resp_t rca_resp;
    } sd_resp_u;

    typedef struct packed {
        logic       wr_en;
        logic [8:0] addr;
        logic [7:0] data;
    } sector_byte_t;

endpackage

`default_nettype wire

/* source/sd_defines.svh */
`ifndef SD_DEFINES_SVH
`define SD_DEFINES_SVH

// short dividers and timeouts when set, real card timing otherwise
`define SD_SIMULATION 1'b1

// clk speed class: 0 up to 25MHz, 1 up to 50MHz, 2 up to 100MHz, 3 up to 200MHz, 4 up to 400MHz
`define SD_CLK_DIV 1

// sdclk half-period in clk cycles minus one, identification and transfer phases
`define SD_SLOW_DIV (`SD_SIMULATION ? 16'd1 : ((16'd1 << `SD_CLK_DIV) * 16'd35))
`define SD_FAST_DIV (`SD_SIMULATION ? 16'd0 : (16'd1 << `SD_CLK_DIV))

// waits counted in sdclk cycles
`define SD_CMD_TIMEOUT (`SD_SIMULATION ? 15'd100 : 15'd500)
`define SD_DAT_TIMEOUT (`SD_SIMULATION ? 32'd200 : 32'd1000000)
`define SD_INIT_PRECYCLES (`SD_SIMULATION ? 16'd16 : 16'd60000)

`define SD_SECTOR_BYTES 512

`endif
